// ==== design/smooth_pkg.sv ====
// smoothing subsystem definitions
`default_nettype none

package smooth_pkg;

	// sample width and delay line depth
	localparam int SAMPLE_W = 16;
	localparam int TAP_COUNT = 16;

	// wide enough for 16 signed 16-bit samples
	localparam int SUM_W = 20;

	// distance back from a threshold before an alarm clears
	localparam int HYST = 64;

	// reciprocal of three scaled by 2^16, rounded up
	localparam int RECIP3_SHIFT = 16;
	localparam logic [15:0] RECIP3 = 16'd21846;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// averaging window, codes 5 to 7 act as 16
	typedef enum logic [2:0] {
		WIN_2  = 3'd0,
		WIN_3  = 3'd1,
		WIN_4  = 3'd2,
		WIN_8  = 3'd3,
		WIN_16 = 3'd4
	} window_e;

	// level monitor state
	typedef enum logic [1:0] {
		LVL_NORMAL = 2'd0,
		LVL_HIGH   = 2'd1,
		LVL_LOW    = 2'd2
	} level_e;

	// alarm thresholds, hi at least lo + 2*HYST
	typedef struct packed {
		sample_t hi;
		sample_t lo;
	} thresh_cfg_t;

	typedef struct packed {
		sample_t max;
		sample_t min;
	} peak_pair_t;

endpackage

`default_nettype wire

// ==== design/ma_filter.sv ====
// moving average filter
`default_nettype none
`timescale 1ns/10ps

module ma_filter (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                flush,
	input  wire smooth_pkg::sample_t sample,
	input  wire smooth_pkg::window_e window,
	output smooth_pkg::sample_t      avg
);

	// delay line, tap 0 is the newest sample
	smooth_pkg::sample_t taps [smooth_pkg::TAP_COUNT];

	// first stage, windowed sum and its window code
	logic signed [smooth_pkg::SUM_W-1:0] sum_d;
	logic signed [smooth_pkg::SUM_W-1:0] sum_q;
	smooth_pkg::window_e                 win_eff;
	smooth_pkg::window_e                 win_q;

	// second stage, divide by three
	logic signed [smooth_pkg::SUM_W+$bits(smooth_pkg::RECIP3):0] prod3;
	logic signed [smooth_pkg::SUM_W-1:0] q3_est;
	logic signed [smooth_pkg::SUM_W-1:0] rem3;
	logic signed [smooth_pkg::SUM_W-1:0] q3;

	// selected quotient
	logic signed [smooth_pkg::SUM_W-1:0] quo;

	// number of taps summed for a window code
	function automatic int win_len(smooth_pkg::window_e w);
		case (w)
			smooth_pkg::WIN_2: return 2;
			smooth_pkg::WIN_3: return 3;
			smooth_pkg::WIN_4: return 4;
			smooth_pkg::WIN_8: return 8;
			default: return 16;
		endcase
	endfunction

	// shift register, flush drops the incoming sample too
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			for (int i = 0; i < smooth_pkg::TAP_COUNT; i++) begin
				taps[i] <= '0;
			end
		end else begin
			taps[0] <= sample;
			for (int i = 1; i < smooth_pkg::TAP_COUNT; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// unused codes fold onto the 16-tap window
	always_comb begin
		case (window)
			smooth_pkg::WIN_2,
			smooth_pkg::WIN_3,
			smooth_pkg::WIN_4,
			smooth_pkg::WIN_8: win_eff = window;
			default: win_eff = smooth_pkg::WIN_16;
		endcase
	end

	// sum of the newest taps, sign extended
	always_comb begin
		sum_d = '0;
		for (int i = 0; i < smooth_pkg::TAP_COUNT; i++) begin
			if (i < win_len(win_eff)) begin
				sum_d = sum_d + smooth_pkg::SUM_W'(taps[i]);
			end
		end
	end

	// reciprocal estimate, off by at most one either way
	assign prod3 = sum_q * $signed({1'b0, smooth_pkg::RECIP3});
	assign q3_est = smooth_pkg::SUM_W'(prod3 >>> smooth_pkg::RECIP3_SHIFT);
	assign rem3 = sum_q - ((q3_est <<< 1) + q3_est);

	// correct toward the floor quotient
	always_comb begin
		if (rem3[smooth_pkg::SUM_W-1]) begin
			q3 = q3_est - smooth_pkg::SUM_W'(1);
		end else if (rem3 >= smooth_pkg::SUM_W'(3)) begin
			q3 = q3_est + smooth_pkg::SUM_W'(1);
		end else begin
			q3 = q3_est;
		end
	end

	// divisor follows the code carried with the sum
	always_comb begin
		case (win_q)
			smooth_pkg::WIN_2: quo = sum_q >>> 1;
			smooth_pkg::WIN_3: quo = q3;
			smooth_pkg::WIN_4: quo = sum_q >>> 2;
			smooth_pkg::WIN_8: quo = sum_q >>> 3;
			default: quo = sum_q >>> 4;
		endcase
	end

	// pipeline registers, flush does not touch them
	always_ff @(posedge clk) begin
		if (rst) begin
			sum_q <= '0;
			win_q <= smooth_pkg::WIN_2;
			avg <= '0;
		end else begin
			sum_q <= sum_d;
			win_q <= win_eff;
			avg <= quo[smooth_pkg::SAMPLE_W-1:0];
		end
	end

	// an unknown code would fold onto the 16-tap divisor unnoticed
	a_win_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(window));

endmodule

`default_nettype wire

// ==== design/level_monitor.sv ====
// level alarm monitor
`default_nettype none
`timescale 1ns/10ps

module level_monitor (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire smooth_pkg::sample_t     avg,
	input  wire smooth_pkg::thresh_cfg_t thresh,
	output smooth_pkg::level_e           level
);

	// thresholds as plain signed samples
	smooth_pkg::sample_t hi;
	smooth_pkg::sample_t lo;

	// release points, one bit wider
	logic signed [smooth_pkg::SAMPLE_W:0] hi_rel;
	logic signed [smooth_pkg::SAMPLE_W:0] lo_rel;

	smooth_pkg::level_e level_d;

	assign hi = thresh.hi;
	assign lo = thresh.lo;

	assign hi_rel = {hi[smooth_pkg::SAMPLE_W-1], hi} -
		(smooth_pkg::SAMPLE_W+1)'(smooth_pkg::HYST);
	assign lo_rel = {lo[smooth_pkg::SAMPLE_W-1], lo} +
		(smooth_pkg::SAMPLE_W+1)'(smooth_pkg::HYST);

	// threshold crossings win over the current state
	always_comb begin
		level_d = level;
		if (avg > hi) begin
			level_d = smooth_pkg::LVL_HIGH;
		end else if (avg < lo) begin
			level_d = smooth_pkg::LVL_LOW;
		end else begin
			case (level)
				smooth_pkg::LVL_HIGH: begin
					// clear once back inside by HYST
					if (avg <= hi_rel) begin
						level_d = smooth_pkg::LVL_NORMAL;
					end
				end
				smooth_pkg::LVL_LOW: begin
					if (avg >= lo_rel) begin
						level_d = smooth_pkg::LVL_NORMAL;
					end
				end
				default: level_d = smooth_pkg::LVL_NORMAL;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			level <= smooth_pkg::LVL_NORMAL;
		end else begin
			level <= level_d;
		end
	end

	// bands must not overlap
	a_thresh_spacing: assert property (@(posedge clk) disable iff (rst)
		int'(hi) >= int'(lo) + 2 * smooth_pkg::HYST);

	// high alarm only raised by an average above hi
	a_high_entry: assert property (@(posedge clk) disable iff (rst)
		(level != smooth_pkg::LVL_HIGH) ##1 (level == smooth_pkg::LVL_HIGH)
		|-> $past(avg > hi));

endmodule

`default_nettype wire

// ==== design/peak_tracker.sv ====
// running peak tracker
`default_nettype none
`timescale 1ns/10ps

module peak_tracker (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                peak_clear,
	input  wire smooth_pkg::sample_t avg,
	output smooth_pkg::peak_pair_t   peaks
);

	// signed running extremes
	smooth_pkg::sample_t max_q;
	smooth_pkg::sample_t min_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			// zero matches avg coming out of reset
			max_q <= '0;
			min_q <= '0;
		end else if (peak_clear) begin
			// restart from the current average
			max_q <= avg;
			min_q <= avg;
		end else begin
			if (avg > max_q) begin
				max_q <= avg;
			end
			if (avg < min_q) begin
				min_q <= avg;
			end
		end
	end

	assign peaks.max = max_q;
	assign peaks.min = min_q;

	// clear and update paths keep the pair ordered
	a_peak_order: assert property (@(posedge clk) disable iff (rst)
		max_q >= min_q);

endmodule

`default_nettype wire

// ==== design/smoothing_channel.sv ====
// sample smoothing channel
`default_nettype none
`timescale 1ns/10ps

module smoothing_channel (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    flush,
	input  wire logic                    peak_clear,
	input  wire smooth_pkg::sample_t     sample,
	input  wire smooth_pkg::window_e     window,
	input  wire smooth_pkg::thresh_cfg_t thresh,
	output smooth_pkg::sample_t          avg,
	output smooth_pkg::level_e           level,
	output smooth_pkg::peak_pair_t       peaks
);

	// averaged stream, two cycles after the sample
	ma_filter i_filter (
		.clk    (clk),
		.rst    (rst),
		.flush  (flush),
		.sample (sample),
		.window (window),
		.avg    (avg)
	);

	// alarm state, one cycle behind avg
	level_monitor i_monitor (
		.clk    (clk),
		.rst    (rst),
		.avg    (avg),
		.thresh (thresh),
		.level  (level)
	);

	// max and min, one cycle behind avg
	peak_tracker i_tracker (
		.clk        (clk),
		.rst        (rst),
		.peak_clear (peak_clear),
		.avg        (avg),
		.peaks      (peaks)
	);

endmodule

`default_nettype wire

// ==== testbench/smoothing_checker.sv ====
// smoothing channel checker
`default_nettype none
`timescale 1ns/10ps

module smoothing_checker (
	input wire logic                    clk,
	input wire logic                    rst,
	input wire logic                    flush,
	input wire logic                    peak_clear,
	input wire smooth_pkg::sample_t     sample,
	input wire logic [2:0]              window,
	input wire smooth_pkg::thresh_cfg_t thresh,
	input wire smooth_pkg::sample_t     avg,
	input wire smooth_pkg::level_e      level,
	input wire smooth_pkg::peak_pair_t  peaks
);

	// model history, index 0 newest
	int hist [smooth_pkg::TAP_COUNT];

	// model pipeline and output state
	int sum_m;
	int len_m;
	int avg_m;
	smooth_pkg::level_e level_m;
	int max_m;
	int min_m;
	bit reset_seen = 1'b0;

	// counters read by the testbench top
	int avg_errors = 0;
	int level_errors = 0;
	int peak_errors = 0;
	int checks = 0;

	// taps averaged for a window code
	function automatic int length_of(logic [2:0] code);
		case (code)
			3'd0: return 2;
			3'd1: return 3;
			3'd2: return 4;
			3'd3: return 8;
			default: return 16;
		endcase
	endfunction

	// integer division rounded toward minus infinity
	function automatic int floor_div(int num, int den);
		int q;
		q = num / den;
		if ((num % den != 0) && (num < 0)) begin
			q = q - 1;
		end
		return q;
	endfunction

	// hysteresis rule
	function automatic smooth_pkg::level_e next_level(smooth_pkg::level_e cur, int a,
		int hi, int lo);
		if (a > hi) begin
			return smooth_pkg::LVL_HIGH;
		end
		if (a < lo) begin
			return smooth_pkg::LVL_LOW;
		end
		if (cur == smooth_pkg::LVL_HIGH && a <= hi - smooth_pkg::HYST) begin
			return smooth_pkg::LVL_NORMAL;
		end
		if (cur == smooth_pkg::LVL_LOW && a >= lo + smooth_pkg::HYST) begin
			return smooth_pkg::LVL_NORMAL;
		end
		return cur;
	endfunction

	// model update, old state feeds every stage
	always @(posedge clk) begin
		int len_now;
		int acc;
		if (rst) begin
			reset_seen = 1'b1;
			foreach (hist[i]) hist[i] = 0;
			sum_m = 0;
			len_m = 2;
			avg_m = 0;
			level_m = smooth_pkg::LVL_NORMAL;
			max_m = 0;
			min_m = 0;
		end else begin
			level_m = next_level(level_m, avg_m, int'(thresh.hi), int'(thresh.lo));
			// peaks from the avg seen at this edge
			if (peak_clear) begin
				max_m = avg_m;
				min_m = avg_m;
			end else begin
				if (avg_m > max_m) max_m = avg_m;
				if (avg_m < min_m) min_m = avg_m;
			end
			avg_m = floor_div(sum_m, len_m);
			// window length in force now goes with the sum
			len_now = length_of(window);
			acc = 0;
			for (int i = 0; i < len_now; i++) begin
				acc = acc + hist[i];
			end
			sum_m = acc;
			len_m = len_now;
			// flush drops the sample at this edge
			if (flush) begin
				foreach (hist[i]) hist[i] = 0;
			end else begin
				for (int i = smooth_pkg::TAP_COUNT - 1; i > 0; i--) begin
					hist[i] = hist[i-1];
				end
				hist[0] = int'(sample);
			end
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		if (reset_seen && !rst) begin
			checks++;
			if (avg !== smooth_pkg::sample_t'(avg_m)) begin
				avg_errors++;
				$display("MISMATCH at %0t: avg expected %0d got %0d", $time, avg_m, avg);
			end
			if (level !== level_m) begin
				level_errors++;
				$display("MISMATCH at %0t: level expected %0d got %0d", $time,
					int'(level_m), int'(level));
			end
			if (peaks.max !== smooth_pkg::sample_t'(max_m)) begin
				peak_errors++;
				$display("MISMATCH at %0t: peaks.max expected %0d got %0d", $time,
					max_m, peaks.max);
			end
			if (peaks.min !== smooth_pkg::sample_t'(min_m)) begin
				peak_errors++;
				$display("MISMATCH at %0t: peaks.min expected %0d got %0d", $time,
					min_m, peaks.min);
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_smoothing_channel.sv ====
// smoothing channel testbench
`default_nettype none
`timescale 1ns/10ps

module tb_smoothing_channel;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int RUN_CYCLES = 4000;
	localparam int MARGIN_CYCLES = 100;

	logic clk;
	logic rst;
	logic flush;
	logic peak_clear;
	smooth_pkg::sample_t sample;
	smooth_pkg::window_e window;
	smooth_pkg::thresh_cfg_t thresh;
	smooth_pkg::sample_t avg;
	smooth_pkg::level_e level;
	smooth_pkg::peak_pair_t peaks;

	// stimulus state
	integer seed;
	int win_left;
	int mode_left;
	int ramp_val;
	int ramp_step;
	bit ramp_mode;
	int lo_pick;
	int gap_pick;
	int total_errors;

	smoothing_channel i_dut (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.peak_clear (peak_clear),
		.sample     (sample),
		.window     (window),
		.thresh     (thresh),
		.avg        (avg),
		.level      (level),
		.peaks      (peaks)
	);

	smoothing_checker i_checker (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.peak_clear (peak_clear),
		.sample     (sample),
		.window     (window),
		.thresh     (thresh),
		.avg        (avg),
		.level      (level),
		.peaks      (peaks)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// uniform draw in 0 .. span-1
	function automatic int rand_below(int span);
		return int'($unsigned($random(seed)) % span);
	endfunction

	// one cycle of window, sample and strobe stimulus
	task automatic drive_cycle();
		if (win_left == 0) begin
			// codes 5 to 7 included
			window <= smooth_pkg::window_e'(3'(rand_below(8)));
			win_left = 20 + rand_below(61);
		end else begin
			win_left--;
		end
		if (mode_left == 0) begin
			ramp_mode = (rand_below(2) == 0);
			if (ramp_mode) begin
				// slow ramp, walks through the alarm bands
				mode_left = 200 + rand_below(401);
				ramp_step = 5 + rand_below(56);
				if (rand_below(2) == 0) ramp_step = -ramp_step;
			end else begin
				mode_left = 50 + rand_below(151);
			end
		end else begin
			mode_left--;
		end
		if (ramp_mode) begin
			ramp_val = ramp_val + ramp_step;
			if (ramp_val > 30000 || ramp_val < -30000) begin
				ramp_step = -ramp_step;
				ramp_val = ramp_val + 2 * ramp_step;
			end
			sample <= smooth_pkg::sample_t'(ramp_val);
		end else begin
			sample <= smooth_pkg::sample_t'($random(seed));
		end
		flush <= (rand_below(300) == 0);
		peak_clear <= (rand_below(200) == 0);
	endtask

	initial begin
		seed = 32'h34e138ad;
		rst = 1'b1;
		flush = 1'b0;
		peak_clear = 1'b0;
		sample = '0;
		window = smooth_pkg::WIN_2;
		thresh.hi = 16'sd1000;
		thresh.lo = -16'sd1000;
		win_left = 0;
		mode_left = 0;
		ramp_val = 0;
		ramp_step = 0;
		ramp_mode = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		// thresholds once, with hi at least lo + 2*HYST
		lo_pick = rand_below(12001) - 8000;
		gap_pick = 2 * smooth_pkg::HYST + rand_below(8001);
		thresh.lo <= smooth_pkg::sample_t'(lo_pick);
		thresh.hi <= smooth_pkg::sample_t'(lo_pick + gap_pick);
		for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
			@(posedge clk);
			drive_cycle();
		end
		// let the last samples drain to level and peaks
		repeat (4) @(posedge clk);
		@(negedge clk);
		#1;
		total_errors = i_checker.avg_errors + i_checker.level_errors + i_checker.peak_errors;
		if (i_checker.checks == 0) begin
			$display("error: no outputs were compared after reset");
		end
		$display("errors: %0d (avg %0d, level %0d, peaks %0d) over %0d compared cycles",
			total_errors, i_checker.avg_errors, i_checker.level_errors,
			i_checker.peak_errors, i_checker.checks);
		if (total_errors == 0 && i_checker.checks > 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// run length plus margin
	initial begin
		#((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("error: watchdog expired, the run did not finish");
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/smooth_pkg.sv
design/ma_filter.sv
design/level_monitor.sv
design/peak_tracker.sv
design/smoothing_channel.sv
testbench/smoothing_checker.sv
testbench/tb_smoothing_channel.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_smoothing_channel \
	-f filelist.f \
	-o sim_smoothing

out=$(./obj_dir/sim_smoothing)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
